//--- dv/tb_xgbe_rx_model.svh
////////////////////////////////////////////////////////////////////////////
// Reference model for the receive PCS testbench
// - Per-lane decode of 66-bit blocks into XGMII bytes
// - Frame state carried across lanes and valid cycles
// - Expected output word, errored-block and frame counters
////////////////////////////////////////////////////////////////////////////
`ifndef TB_XGBE_RX_MODEL_SVH
`define TB_XGBE_RX_MODEL_SVH

logic                                 model_open;
xgbe_rx_pkg::lane_xgmii_t             exp_xgmii;
logic                                 exp_valid;
logic [xgbe_rx_pkg::ERR_CNT_W-1:0]    exp_err;
logic [xgbe_rx_pkg::FRAME_CNT_W-1:0]  exp_frames;

// Data bytes ahead of the terminate, -1 for other types
function automatic int term_count(input logic [7:0] btype);
    case (btype)
        xgbe_rx_pkg::BT_TERM0: return 0;
        xgbe_rx_pkg::BT_TERM1: return 1;
        xgbe_rx_pkg::BT_TERM2: return 2;
        xgbe_rx_pkg::BT_TERM3: return 3;
        xgbe_rx_pkg::BT_TERM4: return 4;
        xgbe_rx_pkg::BT_TERM5: return 5;
        xgbe_rx_pkg::BT_TERM6: return 6;
        xgbe_rx_pkg::BT_TERM7: return 7;
        default:               return -1;
    endcase
endfunction

task automatic reset_model();
    model_open = 1'b0;
    exp_xgmii  = '0;
    exp_valid  = 1'b0;
    exp_err    = '0;
    exp_frames = '0;
endtask

task automatic decode_lane(input xgbe_rx_pkg::pcs_block_t blk, inout logic frame_open,
                           output xgbe_rx_pkg::xgmii_lane_t lane,
                           output logic err, output logic term);
    logic [7:0] btype;
    int         k;
    btype = blk.payload[7:0];
    k     = term_count(btype);
    err   = 1'b0;
    term  = 1'b0;
    if (blk.hdr == xgbe_rx_pkg::SYNC_DATA && frame_open) begin
        lane.ctrl = 8'h00;
        lane.data = blk.payload;
    end else if (blk.hdr == xgbe_rx_pkg::SYNC_CTRL && btype == xgbe_rx_pkg::BT_IDLE
                 && !frame_open) begin
        lane.ctrl = 8'hFF;
        lane.data = {8{xgbe_rx_pkg::XGMII_IDLE}};
    end else if (blk.hdr == xgbe_rx_pkg::SYNC_CTRL && btype == xgbe_rx_pkg::BT_START
                 && !frame_open) begin
        lane.ctrl      = 8'h01;
        lane.data      = blk.payload;
        lane.data[7:0] = xgbe_rx_pkg::XGMII_START;
        frame_open     = 1'b1;
    end else if (blk.hdr == xgbe_rx_pkg::SYNC_CTRL && k >= 0 && frame_open) begin
        for (int b = 0; b < 8; b++) begin
            lane.ctrl[b] = (b >= k);
            if (b < k)
                lane.data[8*b +: 8] = blk.payload[8*(b+1) +: 8];
            else if (b == k)
                lane.data[8*b +: 8] = xgbe_rx_pkg::XGMII_TERM;
            else
                lane.data[8*b +: 8] = xgbe_rx_pkg::XGMII_IDLE;
        end
        term       = 1'b1;
        frame_open = 1'b0;
    end else begin
        lane.ctrl  = 8'hFF;
        lane.data  = {8{xgbe_rx_pkg::XGMII_ERROR}};
        err        = 1'b1;
        frame_open = 1'b0;
    end
endtask

// Expected outputs after the edge that samples these inputs
task automatic model_step(input xgbe_rx_pkg::lane_blocks_t blks, input logic valid,
                          input logic clr);
    xgbe_rx_pkg::xgmii_lane_t lane;
    logic                     e;
    logic                     t;
    int                       errs;
    int                       sum;
    errs = 0;
    if (valid) begin
        for (int i = 0; i < xgbe_rx_pkg::NUM_LANES; i++) begin
            decode_lane(blks[i], model_open, lane, e, t);
            exp_xgmii[i] = lane;
            errs         = errs + e;
            exp_frames   = exp_frames + t;
        end
    end
    sum = exp_err + errs;
    if (clr)
        exp_err = '0;
    else if (valid)
        exp_err = (sum > (1 << xgbe_rx_pkg::ERR_CNT_W) - 1) ? '1 : sum[7:0];
    exp_valid = valid;
endtask

`endif

//--- dv/tb_xgbe_rx.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the four-lane receive PCS
// - Clock, reset and seeded random block stimulus
// - Directed error burst for counter saturation and clear
// - Output checks against the included reference model, cycle timeout
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_xgbe_rx;

    localparam int RESET_CYCLES = 16;
    localparam int STIM_CYCLES  = 3000;
    // Reset plus stimulus plus drain, rounded up with margin
    localparam int CYCLE_LIMIT  = 4000;
    localparam int BURST_START  = 200;
    localparam int BURST_END    = 300;

    logic                                 clk_156;
    logic                                 async_reset_n;
    xgbe_rx_pkg::lane_blocks_t            blocks_i;
    logic                                 blocks_valid_i;
    logic                                 clear_errblk_i;
    xgbe_rx_pkg::lane_xgmii_t             xgmii_o;
    logic                                 xgmii_valid_o;
    logic [xgbe_rx_pkg::ERR_CNT_W-1:0]    errd_blks_o;
    logic [xgbe_rx_pkg::FRAME_CNT_W-1:0]  frame_count_o;
    integer                               seed;
    int                                   cycle_cnt;
    logic                                 gen_open;

    `include "tb_xgbe_rx_model.svh"

    xgbe_rx_top dut_i (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .blocks_i       (blocks_i),
        .blocks_valid_i (blocks_valid_i),
        .clear_errblk_i (clear_errblk_i),
        .xgmii_o        (xgmii_o),
        .xgmii_valid_o  (xgmii_valid_o),
        .errd_blks_o    (errd_blks_o),
        .frame_count_o  (frame_count_o)
    );

    initial clk_156 = 1'b0;
    always #50 clk_156 = ~clk_156;

    always @(posedge clk_156) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic report_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first mismatch");
    endtask

    function automatic logic [7:0] term_code(input logic [2:0] k);
        case (k)
            3'd0:    return xgbe_rx_pkg::BT_TERM0;
            3'd1:    return xgbe_rx_pkg::BT_TERM1;
            3'd2:    return xgbe_rx_pkg::BT_TERM2;
            3'd3:    return xgbe_rx_pkg::BT_TERM3;
            3'd4:    return xgbe_rx_pkg::BT_TERM4;
            3'd5:    return xgbe_rx_pkg::BT_TERM5;
            3'd6:    return xgbe_rx_pkg::BT_TERM6;
            default: return xgbe_rx_pkg::BT_TERM7;
        endcase
    endfunction

    // Frame grammar with occasional bad header, unknown type or wrong order
    task automatic make_block(output xgbe_rx_pkg::pcs_block_t blk);
        int roll;
        roll        = $unsigned($random(seed)) % 32;
        blk.payload = {$random(seed), $random(seed)};
        blk.hdr     = xgbe_rx_pkg::SYNC_CTRL;
        if (roll == 0) begin
            blk.hdr  = blk.payload[63] ? 2'b11 : 2'b00;
            gen_open = 1'b0;
        end else if (roll == 1) begin
            blk.payload[7:0] = 8'h55;
            gen_open         = 1'b0;
        end else if (roll == 2) begin
            // Start or idle inside a frame, data or terminate outside one
            if (gen_open)
                blk.payload[7:0] = blk.payload[8] ? xgbe_rx_pkg::BT_START
                                                  : xgbe_rx_pkg::BT_IDLE;
            else if (blk.payload[8])
                blk.hdr = xgbe_rx_pkg::SYNC_DATA;
            else
                blk.payload[7:0] = term_code(blk.payload[63:61]);
            gen_open = 1'b0;
        end else if (!gen_open) begin
            blk.payload[7:0] = (roll < 18) ? xgbe_rx_pkg::BT_IDLE : xgbe_rx_pkg::BT_START;
            gen_open         = (roll >= 18);
        end else if (roll < 26) begin
            blk.hdr = xgbe_rx_pkg::SYNC_DATA;
        end else begin
            blk.payload[7:0] = term_code(blk.payload[63:61]);
            gen_open         = 1'b0;
        end
    endtask

    task automatic build_cycle(input int c, output xgbe_rx_pkg::lane_blocks_t blks,
                               output logic valid, output logic clr);
        logic saved_open;
        valid = 1'b1;
        clr   = 1'b0;
        for (int i = 0; i < xgbe_rx_pkg::NUM_LANES; i++) begin
            blks[i].payload = {$random(seed), $random(seed)};
            blks[i].hdr     = (c == 0) ? xgbe_rx_pkg::SYNC_DATA : 2'b11;
        end
        // First cycle sends data into a closed frame, the burst drives errors
        if (c >= BURST_START && c < BURST_END) begin
            clr      = (c == BURST_END - 1);
            gen_open = 1'b0;
        end else if (c != 0) begin
            valid      = ($unsigned($random(seed)) % 8) != 0;
            clr        = ($unsigned($random(seed)) % 150) == 0;
            saved_open = gen_open;
            for (int i = 0; i < xgbe_rx_pkg::NUM_LANES; i++)
                make_block(blks[i]);
            if (!valid)
                gen_open = saved_open;
        end
    endtask

    task automatic check_outputs();
        assert (xgmii_valid_o === exp_valid)
            else report_error($sformatf("xgmii_valid_o %b, expected %b",
                                        xgmii_valid_o, exp_valid));
        if (exp_valid) begin
            for (int i = 0; i < xgbe_rx_pkg::NUM_LANES; i++)
                assert (xgmii_o[i] === exp_xgmii[i])
                    else report_error($sformatf("lane %0d ctrl %h data %h, expected %h %h",
                                                i, xgmii_o[i].ctrl, xgmii_o[i].data,
                                                exp_xgmii[i].ctrl, exp_xgmii[i].data));
        end
        assert (errd_blks_o === exp_err)
            else report_error($sformatf("errd_blks_o %0d, expected %0d", errd_blks_o, exp_err));
        assert (frame_count_o === exp_frames)
            else report_error($sformatf("frame_count_o %0d, expected %0d",
                                        frame_count_o, exp_frames));
    endtask

    initial begin
        xgbe_rx_pkg::lane_blocks_t blk_next;
        logic                      valid_next;
        logic                      clr_next;
        seed           = 4;
        cycle_cnt      = 0;
        gen_open       = 1'b0;
        async_reset_n  = 1'b0;
        blocks_i       = '0;
        blocks_valid_i = 1'b0;
        clear_errblk_i = 1'b0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk_156);
        async_reset_n <= 1'b1;
        for (int c = 0; c < STIM_CYCLES; c++) begin
            @(posedge clk_156);
            build_cycle(c, blk_next, valid_next, clr_next);
            blocks_i       <= blk_next;
            blocks_valid_i <= valid_next;
            clear_errblk_i <= clr_next;
            // Outputs here still reflect the previous cycle's inputs
            @(negedge clk_156);
            check_outputs();
            model_step(blk_next, valid_next, clr_next);
        end
        @(posedge clk_156);
        blocks_valid_i <= 1'b0;
        clear_errblk_i <= 1'b0;
        @(negedge clk_156);
        check_outputs();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+dv
logic/xgbe_rx_pkg.sv
logic/rx_block_decoder.sv
logic/rx_lane_chain.sv
logic/rx_output_stage.sv
logic/xgbe_rx_top.sv
dv/tb_xgbe_rx.sv

//--- logic/rx_block_decoder.sv
////////////////////////////////////////////////////////////////////////////
// 64b/66b block decoder for one receive lane
// - Sync header and block type classification
// - Legality check against the incoming frame state
// - XGMII byte and control flag mapping, error block substitution
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_block_decoder (
    input  xgbe_rx_pkg::pcs_block_t  block_i,
    input  logic                     frame_open_i,
    output xgbe_rx_pkg::xgmii_lane_t lane_o,
    output logic                     frame_open_o,
    output logic                     blk_err_o,
    output logic                     term_o
);

    xgbe_rx_pkg::block_type_e        btype;
    logic                            is_term;
    logic [2:0]                      term_pos;
    logic [xgbe_rx_pkg::DATA_W-1:0]  term_src;

    assign btype = xgbe_rx_pkg::block_type_e'(block_i.payload[7:0]);

    // Terminate data bytes start at payload byte 1
    assign term_src = block_i.payload >> 8;

    // Terminate position from the block type
    always_comb begin
        is_term  = 1'b1;
        term_pos = 3'd0;
        case (btype)
            xgbe_rx_pkg::BT_TERM0: term_pos = 3'd0;
            xgbe_rx_pkg::BT_TERM1: term_pos = 3'd1;
            xgbe_rx_pkg::BT_TERM2: term_pos = 3'd2;
            xgbe_rx_pkg::BT_TERM3: term_pos = 3'd3;
            xgbe_rx_pkg::BT_TERM4: term_pos = 3'd4;
            xgbe_rx_pkg::BT_TERM5: term_pos = 3'd5;
            xgbe_rx_pkg::BT_TERM6: term_pos = 3'd6;
            xgbe_rx_pkg::BT_TERM7: term_pos = 3'd7;
            default:               is_term  = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Error block unless a legal case below claims it
        lane_o.ctrl  = '1;
        lane_o.data  = {(xgbe_rx_pkg::DATA_W/8){xgbe_rx_pkg::XGMII_ERROR}};
        blk_err_o    = 1'b1;
        term_o       = 1'b0;
        frame_open_o = 1'b0;

        if (block_i.hdr == xgbe_rx_pkg::SYNC_DATA) begin
            if (frame_open_i) begin
                lane_o.ctrl  = '0;
                lane_o.data  = block_i.payload;
                blk_err_o    = 1'b0;
                frame_open_o = 1'b1;
            end
        end else if (block_i.hdr == xgbe_rx_pkg::SYNC_CTRL) begin
            if (btype == xgbe_rx_pkg::BT_IDLE && !frame_open_i) begin
                lane_o.data = {(xgbe_rx_pkg::DATA_W/8){xgbe_rx_pkg::XGMII_IDLE}};
                blk_err_o   = 1'b0;
            end else if (btype == xgbe_rx_pkg::BT_START && !frame_open_i) begin
                // Start character replaces the type byte
                lane_o.ctrl  = {{(xgbe_rx_pkg::DATA_W/8-1){1'b0}}, 1'b1};
                lane_o.data  = {block_i.payload[xgbe_rx_pkg::DATA_W-1:8],
                                xgbe_rx_pkg::XGMII_START};
                blk_err_o    = 1'b0;
                frame_open_o = 1'b1;
            end else if (is_term && frame_open_i) begin
                for (int i = 0; i < xgbe_rx_pkg::DATA_W/8; i++) begin
                    if (i < term_pos) begin
                        lane_o.ctrl[i]       = 1'b0;
                        lane_o.data[8*i +: 8] = term_src[8*i +: 8];
                    end else if (i == term_pos) begin
                        lane_o.ctrl[i]       = 1'b1;
                        lane_o.data[8*i +: 8] = xgbe_rx_pkg::XGMII_TERM;
                    end else begin
                        lane_o.ctrl[i]       = 1'b1;
                        lane_o.data[8*i +: 8] = xgbe_rx_pkg::XGMII_IDLE;
                    end
                end
                blk_err_o = 1'b0;
                term_o    = 1'b1;
            end
        end

        // A terminate is only reported for a legal block
        err_term_excl: assert #0 (!(blk_err_o && term_o));
    end

endmodule

`default_nettype wire

//--- logic/rx_lane_chain.sv
////////////////////////////////////////////////////////////////////////////
// Four chained lane decoders
// - Frame state passed from each lane to the next
// - Register carrying lane 3 state into lane 0 of the next valid cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_lane_chain (
    input  logic                               clk_156,
    input  logic                               async_reset_n,
    input  xgbe_rx_pkg::lane_blocks_t          blocks_i,
    input  logic                               blocks_valid_i,
    output xgbe_rx_pkg::lane_xgmii_t           lanes_o,
    output logic                               lanes_valid_o,
    output logic [xgbe_rx_pkg::NUM_LANES-1:0]  blk_err_o,
    output logic [xgbe_rx_pkg::NUM_LANES-1:0]  term_o
);

    // open_chain[i] feeds lane i, the last entry leaves lane 3
    logic [xgbe_rx_pkg::NUM_LANES:0] open_chain;
    logic                            frame_open_q;

    assign open_chain[0] = frame_open_q;
    assign lanes_valid_o = blocks_valid_i;

    for (genvar g = 0; g < xgbe_rx_pkg::NUM_LANES; g++) begin : g_lane
        rx_block_decoder u_dec (
            .block_i      (blocks_i[g]),
            .frame_open_i (open_chain[g]),
            .lane_o       (lanes_o[g]),
            .frame_open_o (open_chain[g+1]),
            .blk_err_o    (blk_err_o[g]),
            .term_o       (term_o[g])
        );
    end

    // Frame state across cycles, held on idle strobes
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            frame_open_q <= 1'b0;
        end else if (blocks_valid_i) begin
            frame_open_q <= open_chain[xgbe_rx_pkg::NUM_LANES];
        end
    end

    valid_known: assert property (
        @(posedge clk_156) disable iff (!async_reset_n)
        !$isunknown(blocks_valid_i)
    );

endmodule

`default_nettype wire

//--- logic/rx_output_stage.sv
////////////////////////////////////////////////////////////////////////////
// Output register for the decoded four-lane word
// - Saturating errored-block counter with clear
// - Wrapping completed-frame counter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_output_stage (
    input  logic                                 clk_156,
    input  logic                                 async_reset_n,
    input  xgbe_rx_pkg::lane_xgmii_t             lanes_i,
    input  logic                                 lanes_valid_i,
    input  logic [xgbe_rx_pkg::NUM_LANES-1:0]    blk_err_i,
    input  logic [xgbe_rx_pkg::NUM_LANES-1:0]    term_i,
    input  logic                                 clear_errblk_i,
    output xgbe_rx_pkg::lane_xgmii_t             xgmii_o,
    output logic                                 xgmii_valid_o,
    output logic [xgbe_rx_pkg::ERR_CNT_W-1:0]    errd_blks_o,
    output logic [xgbe_rx_pkg::FRAME_CNT_W-1:0]  frame_count_o
);

    logic [xgbe_rx_pkg::ERR_CNT_W:0]     err_add;
    logic [xgbe_rx_pkg::ERR_CNT_W:0]     err_sum;
    logic [xgbe_rx_pkg::FRAME_CNT_W-1:0] term_add;

    // Flagged lanes this cycle
    always_comb begin
        err_add  = '0;
        term_add = '0;
        for (int i = 0; i < xgbe_rx_pkg::NUM_LANES; i++) begin
            err_add  = err_add + blk_err_i[i];
            term_add = term_add + term_i[i];
        end
    end

    assign err_sum = {1'b0, errd_blks_o} + err_add;

    always_ff @(posedge clk_156) begin
        if (lanes_valid_i) begin
            xgmii_o <= lanes_i;
        end
    end

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            xgmii_valid_o <= 1'b0;
            errd_blks_o   <= '0;
            frame_count_o <= '0;
        end else begin
            xgmii_valid_o <= lanes_valid_i;
            // Clear wins over errors in the same cycle
            if (clear_errblk_i) begin
                errd_blks_o <= '0;
            end else if (lanes_valid_i) begin
                errd_blks_o <= err_sum[xgbe_rx_pkg::ERR_CNT_W] ? '1 :
                               err_sum[xgbe_rx_pkg::ERR_CNT_W-1:0];
            end
            if (lanes_valid_i) begin
                frame_count_o <= frame_count_o + term_add;
            end
        end
    end

    errd_monotonic: assert property (
        @(posedge clk_156) disable iff (!async_reset_n)
        !clear_errblk_i |=> errd_blks_o >= $past(errd_blks_o)
    );

endmodule

`default_nettype wire

//--- logic/xgbe_rx_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the four-lane 10G Ethernet PCS receive path
// - Lane count and field widths
// - Sync headers and XGMII control characters
// - 64b/66b block type codes accepted by the decoders
// - Block and XGMII lane structs
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package xgbe_rx_pkg;

    localparam int NUM_LANES   = 4;
    localparam int DATA_W      = 64;
    localparam int HDR_W       = 2;
    localparam int ERR_CNT_W   = 8;
    localparam int FRAME_CNT_W = 16;

    // Sync headers
    localparam logic [HDR_W-1:0] SYNC_DATA = 2'b01;
    localparam logic [HDR_W-1:0] SYNC_CTRL = 2'b10;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;

    // Block type field, payload byte 0
    // TERMk carries k data bytes ahead of the terminate
    typedef enum logic [7:0] {
        BT_IDLE  = 8'h1E,
        BT_START = 8'h78,
        BT_TERM0 = 8'h87,
        BT_TERM1 = 8'h99,
        BT_TERM2 = 8'hAA,
        BT_TERM3 = 8'hB4,
        BT_TERM4 = 8'hCC,
        BT_TERM5 = 8'hD2,
        BT_TERM6 = 8'hE1,
        BT_TERM7 = 8'hFF
    } block_type_e;

    typedef struct packed {
        logic [HDR_W-1:0]  hdr;
        logic [DATA_W-1:0] payload;
    } pcs_block_t;

    // Bit i of ctrl marks byte i of data as a control character
    typedef struct packed {
        logic [DATA_W/8-1:0] ctrl;
        logic [DATA_W-1:0]   data;
    } xgmii_lane_t;

    // Index 0 is the earliest lane
    typedef pcs_block_t  [NUM_LANES-1:0] lane_blocks_t;
    typedef xgmii_lane_t [NUM_LANES-1:0] lane_xgmii_t;

endpackage

`default_nettype wire

//--- logic/xgbe_rx_top.sv
////////////////////////////////////////////////////////////////////////////
// Receive PCS top level for four 66-bit lanes
// - Chained lane decoders feeding the registered XGMII output stage
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module xgbe_rx_top (
    input  logic                                 clk_156,
    input  logic                                 async_reset_n,
    input  xgbe_rx_pkg::lane_blocks_t            blocks_i,
    input  logic                                 blocks_valid_i,
    input  logic                                 clear_errblk_i,
    output xgbe_rx_pkg::lane_xgmii_t             xgmii_o,
    output logic                                 xgmii_valid_o,
    output logic [xgbe_rx_pkg::ERR_CNT_W-1:0]    errd_blks_o,
    output logic [xgbe_rx_pkg::FRAME_CNT_W-1:0]  frame_count_o
);

    xgbe_rx_pkg::lane_xgmii_t             dec_lanes;
    logic                                 dec_valid;
    logic [xgbe_rx_pkg::NUM_LANES-1:0]    dec_err;
    logic [xgbe_rx_pkg::NUM_LANES-1:0]    dec_term;

    rx_lane_chain u_chain (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .blocks_i       (blocks_i),
        .blocks_valid_i (blocks_valid_i),
        .lanes_o        (dec_lanes),
        .lanes_valid_o  (dec_valid),
        .blk_err_o      (dec_err),
        .term_o         (dec_term)
    );

    rx_output_stage u_out (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .lanes_i        (dec_lanes),
        .lanes_valid_i  (dec_valid),
        .blk_err_i      (dec_err),
        .term_i         (dec_term),
        .clear_errblk_i (clear_errblk_i),
        .xgmii_o        (xgmii_o),
        .xgmii_valid_o  (xgmii_valid_o),
        .errd_blks_o    (errd_blks_o),
        .frame_count_o  (frame_count_o)
    );

endmodule

`default_nettype wire
